/* sources.f */
hdl/frontend_pkg.sv
hdl/predict_if.sv
hdl/predictor_bank.sv
hdl/branch_predictor.sv
hdl/fetch_stage.sv
hdl/frontend_top.sv
verification/frontend_assert.sv
verification/frontend_tb.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0
SIM_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;
    import frontend_pkg::*;

    localparam int          PROG_WORDS = 64;
    localparam logic [31:0] LFSR_SEED  = 32'h3744;
    localparam instr_t      NOP        = 32'h0000_0013;  // addi x0, x0, 0

    logic   clk;
    logic   reset_n;
    instr_t instr;
    logic   pc_write;
    logic   ex_taken;
    addr_t  address;
    logic   if_id_flush;
    logic   id_ex_flush;

    // program image and its kind per word (0 nop, 1 branch, 2 jal)
    instr_t     prog_word [PROG_WORDS];
    logic [1:0] prog_kind [PROG_WORDS];
    addr_t      prog_off  [PROG_WORDS];
    logic [1:0] outcome   [PROG_WORDS];  // 0 not taken, 1 taken, 2 lfsr bit

    logic [31:0] lfsr;
    logic        stall_en;
    int          mismatches = 0;
    int          timeouts = 0;
    int          assert_fails;

    // reference copy of pc, both slots and the counters
    addr_t      m_pc;
    logic       m_s1_valid;
    logic       m_s1_branch;
    addr_t      m_s1_pc;
    addr_t      m_s1_off;
    logic       m_s1_pred;
    logic       m_s2_valid;
    logic       m_s2_branch;
    addr_t      m_s2_pc;
    addr_t      m_s2_off;
    logic       m_s2_pred;
    ctr_state_t m_ctr [NUM_BANKS*BANK_ENTRIES];

    frontend_top UUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr       (instr),
        .pc_write    (pc_write),
        .ex_taken    (ex_taken),
        .address     (address),
        .if_id_flush (if_id_flush),
        .id_ex_flush (id_ex_flush)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(rand_bit());
        end
        return v;
    endfunction

    function automatic logic in_program(addr_t a);
        return (a >> 2) < 32'(PROG_WORDS);
    endfunction

    function automatic logic [5:0] word_of(addr_t a);
        return a[7:2];
    endfunction

    function automatic instr_t fetch_word(addr_t a);
        return in_program(a) ? prog_word[word_of(a)] : NOP;
    endfunction

    function automatic logic [1:0] kind_at(addr_t a);
        return in_program(a) ? prog_kind[word_of(a)] : 2'd0;
    endfunction

    function automatic addr_t off_at(addr_t a);
        return in_program(a) ? prog_off[word_of(a)] : '0;
    endfunction

    // bank major counter layout
    function automatic logic [BANK_SEL_W+ENTRY_SEL_W-1:0] ctr_index(addr_t pc);
        return {pc[2 +: BANK_SEL_W], pc[2 + BANK_SEL_W +: ENTRY_SEL_W]};
    endfunction

    function automatic ctr_state_t ctr_step(ctr_state_t c, logic taken);
        if (taken) begin
            return (c == strong_taken) ? strong_taken : ctr_state_t'(c + 2'd1);
        end
        return (c == strong_not_taken) ? strong_not_taken : ctr_state_t'(c - 2'd1);
    endfunction

    function automatic void clear_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_word[i] = NOP;
            prog_kind[i] = 2'd0;
            prog_off[i]  = '0;
            outcome[i]   = 2'd0;
        end
    endfunction

    function automatic void put_branch(logic [5:0] at, logic [5:0] target, logic [1:0] mode);
        addr_t off;
        off = addr_t'((int'(target) - int'(at)) * 4);
        prog_word[at] = {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11],
                         OPCODE_BRANCH};  // beq x1, x2
        prog_kind[at] = 2'd1;
        prog_off[at]  = off;
        outcome[at]   = mode;
    endfunction

    function automatic void put_jal(logic [5:0] at, logic [5:0] target);
        addr_t off;
        off = addr_t'((int'(target) - int'(at)) * 4);
        prog_word[at] = {off[20], off[10:1], off[11], off[19:12], 5'd1, OPCODE_JAL};
        prog_kind[at] = 2'd2;
        prog_off[at]  = off;
    endfunction

    // random jals jump forward and the last word wraps to zero
    function automatic void random_program();
        int r;
        clear_program();
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            r = rand_bits(3);
            if (r < 3) begin
                put_branch(6'(i), 6'(rand_bits(6)), 2'(rand_bits(2) == 3 ? 2 : rand_bits(1)));
            end else if (r == 3) begin
                put_jal(6'(i), 6'(i + 1 + rand_bits(6) % (PROG_WORDS - 1 - i)));
            end
        end
        put_jal(6'(PROG_WORDS - 1), 6'd0);
    endfunction

    function automatic void model_reset();
        m_pc       = RESET_PC;
        m_s1_valid = 1'b0;
        m_s2_valid = 1'b0;
        for (int i = 0; i < NUM_BANKS*BANK_ENTRIES; i++) begin
            m_ctr[i] = CTR_RESET;
        end
    endfunction

    function automatic logic expected_flush(logic wr, logic taken);
        return wr && m_s2_valid && m_s2_branch && (taken != m_s2_pred);
    endfunction

    // one clock edge of the front end
    function automatic void next_state(logic wr, logic taken);
        logic  resolve;
        logic  mis;
        logic  fetch_pred;
        addr_t npc;
        if (!wr) begin
            return;
        end
        resolve    = m_s2_valid && m_s2_branch;
        mis        = resolve && (taken != m_s2_pred);
        fetch_pred = m_ctr[ctr_index(m_pc)][1];  // lookup sees the old counter
        if (resolve) begin
            m_ctr[ctr_index(m_s2_pc)] = ctr_step(m_ctr[ctr_index(m_s2_pc)], taken);
        end
        if (mis) begin
            npc = taken ? m_s2_pc + m_s2_off : m_s2_pc + 32'd4;
        end else if (kind_at(m_pc) == 2'd2) begin
            npc = m_pc + off_at(m_pc);
        end else if (kind_at(m_pc) == 2'd1 && fetch_pred) begin
            npc = m_pc + off_at(m_pc);
        end else begin
            npc = m_pc + 32'd4;
        end
        m_s2_valid  = m_s1_valid && !mis;
        m_s2_branch = m_s1_branch;
        m_s2_pc     = m_s1_pc;
        m_s2_off    = m_s1_off;
        m_s2_pred   = m_s1_pred;
        m_s1_valid  = !mis;
        m_s1_branch = (kind_at(m_pc) == 2'd1);
        m_s1_pc     = m_pc;
        m_s1_off    = off_at(m_pc);
        m_s1_pred   = fetch_pred;
        m_pc        = npc;
    endfunction

    // execute stage answer for the branch in slot two
    function automatic logic resolve_outcome();
        logic [1:0] mode;
        if (!(m_s2_valid && m_s2_branch)) begin
            return 1'b0;
        end
        mode = outcome[word_of(m_s2_pc)];
        return (mode == 2'd2) ? rand_bit() : mode[0];
    endfunction

    always @(negedge clk) begin : compare
        logic exp_fl;
        if (!reset_n) begin
            model_reset();
        end
        exp_fl = expected_flush(pc_write, ex_taken);
        if (address !== m_pc) begin
            mismatches++;
            $display("Fail t=%0t address got %h expected %h", $time, address, m_pc);
        end
        if (if_id_flush !== exp_fl) begin
            mismatches++;
            $display("Fail t=%0t if_id_flush got %b expected %b", $time, if_id_flush, exp_fl);
        end
        if (id_ex_flush !== exp_fl) begin
            mismatches++;
            $display("Fail t=%0t id_ex_flush got %b expected %b", $time, id_ex_flush, exp_fl);
        end
        if (reset_n) begin
            next_state(pc_write, ex_taken);
        end
    end

    task automatic drive_cycle();
        @(posedge clk);
        #1;
        pc_write = stall_en ? (rand_bits(2) != 3) : 1'b1;
        instr    = fetch_word(address);
        ex_taken = resolve_outcome();
        #2;  // let outputs settle before sampling
    endtask

    task automatic run_cycles(int n);
        repeat (n) drive_cycle();
    endtask

    task automatic apply_reset();
        reset_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset_n  = 1'b1;
        pc_write = 1'b1;
        ex_taken = 1'b0;
        instr    = fetch_word(address);
    endtask

    task automatic wait_address(addr_t target, int limit, string what);
        int n;
        n = 0;
        while (address !== target && n < limit) begin
            drive_cycle();
            n++;
        end
        if (address !== target) begin
            timeouts++;
            $display("timeout after %0d cycles waiting for %s", limit, what);
        end
    endtask

    task automatic wait_flush(int limit, string what);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            drive_cycle();
            seen = if_id_flush;
            n++;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout after %0d cycles waiting for %s", limit, what);
        end
    endtask

    initial begin
        lfsr     = LFSR_SEED;
        stall_en = 1'b0;
        reset_n  = 1'b0;
        instr    = NOP;
        pc_write = 1'b0;
        ex_taken = 1'b0;

        clear_program();  // straight line
        apply_reset();
        wait_address(32'h40, 40, "straight-line pc 0x40");

        // straight-line fetch would need ten cycles to get there
        clear_program();
        put_jal(6'd2, 6'd10);
        apply_reset();
        wait_address(32'h28, 5, "jal target 0x28");
        run_cycles(6);

        // loop branch at 0x14 back to 0x08 and a jal at 0x20 closing the fall-through path
        clear_program();
        put_branch(6'd5, 6'd2, 2'd1);
        put_jal(6'd8, 6'd2);
        apply_reset();
        wait_flush(30, "first taken mispredict");
        run_cycles(40);
        outcome[5] = 2'd0;
        wait_flush(30, "first not-taken mispredict");
        wait_flush(30, "second not-taken mispredict");
        run_cycles(30);

        outcome[5] = 2'd2;
        stall_en   = 1'b1;
        run_cycles(150);

        random_program();
        apply_reset();
        run_cycles(250);
        stall_en = 1'b0;
        run_cycles(250);

        assert_fails = UUT.u_checks.flush_fail + UUT.u_checks.stall_fail +
                       UUT.u_checks.stable_fail;
        $display("summary: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, assert_fails);
        if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/frontend_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_assert_checks (
    input wire                      clk,
    input wire                      reset_n,
    input wire                      pc_write,
    input wire frontend_pkg::addr_t address,
    input wire                      if_id_flush,
    input wire                      id_ex_flush
);

    int flush_fail = 0;
    int stall_fail = 0;
    int stable_fail = 0;

    // both younger slots die together
    flush_pair: assert property (@(posedge clk) disable iff (!reset_n)
        if_id_flush == id_ex_flush)
    else begin
        flush_fail++;
        $error("if_id_flush and id_ex_flush differ");
    end

    no_flush_in_stall: assert property (@(posedge clk) disable iff (!reset_n)
        !pc_write |-> !if_id_flush)
    else begin
        stall_fail++;
        $error("flush raised while pc_write is low");
    end

    pc_held_in_stall: assert property (@(posedge clk) disable iff (!reset_n)
        !pc_write |=> $stable(address))
    else begin
        stable_fail++;
        $error("address moved across a stalled cycle");
    end

endmodule

bind frontend_top frontend_assert_checks u_checks (.*);

`default_nettype wire

/* hdl/frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_top (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire frontend_pkg::instr_t instr,        // word at address, same cycle
    input  wire                       pc_write,
    input  wire                       ex_taken,     // outcome of the branch in execute
    output frontend_pkg::addr_t       address,
    output logic                      if_id_flush,
    output logic                      id_ex_flush
);

    predict_if pred_bus ();

    // pc, slots, redirect and flush
    fetch_stage u_fetch (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr       (instr),
        .pc_write    (pc_write),
        .ex_taken    (ex_taken),
        .pred        (pred_bus.fetch),
        .address     (address),
        .if_id_flush (if_id_flush),
        .id_ex_flush (id_ex_flush)
    );

    // banked 2-bit counters
    branch_predictor u_predictor (
        .clk     (clk),
        .reset_n (reset_n),
        .pred    (pred_bus.predictor)
    );

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire frontend_pkg::instr_t instr,
    input  wire                       pc_write,
    input  wire                       ex_taken,
    predict_if.fetch                  pred,
    output frontend_pkg::addr_t       address,
    output logic                      if_id_flush,
    output logic                      id_ex_flush
);
    import frontend_pkg::*;

    addr_t   pc_reg;
    addr_t   pc_next;
    opcode_t opcode;
    logic    is_branch;
    logic    is_jal;
    addr_t   offset_0;  // sign extended B or J immediate

    // slot one (decode) and slot two (execute)
    logic  s1_valid, s2_valid;
    logic  s1_branch, s2_branch;
    addr_t s1_pc, s2_pc;
    addr_t s1_offset, s2_offset;
    logic  s1_pred, s2_pred;

    logic  resolve;
    logic  mispredict;
    addr_t redirect_pc;

    assign opcode    = instr[6:0];
    assign is_branch = (opcode == OPCODE_BRANCH);
    assign is_jal    = (opcode == OPCODE_JAL);

    always_comb begin
        case (opcode)
            OPCODE_BRANCH: offset_0 = {{20{instr[31]}}, instr[7], instr[30:25],
                                       instr[11:8], 1'b0};
            OPCODE_JAL:    offset_0 = {{12{instr[31]}}, instr[19:12], instr[20],
                                       instr[30:21], 1'b0};
            default:       offset_0 = '0;
        endcase
    end

    assign pred.lookup_pc = pc_reg;

    // branch in execute gets its outcome this cycle
    assign resolve    = pc_write && s2_valid && s2_branch;
    assign mispredict = resolve && (ex_taken != s2_pred);

    // target from the branch's own pc rather than the fetch pc
    assign redirect_pc = ex_taken ? s2_pc + s2_offset : s2_pc + 32'd4;

    assign if_id_flush = mispredict;
    assign id_ex_flush = mispredict;

    // counter trained on every resolution whether right or wrong
    assign pred.update_valid = resolve;
    assign pred.update_pc    = s2_pc;
    assign pred.update_taken = ex_taken;

    always_comb begin
        if (!pc_write) begin
            pc_next = pc_reg;  // stall
        end else if (mispredict) begin
            pc_next = redirect_pc;
        end else if (is_jal || (is_branch && pred.lookup_taken)) begin
            pc_next = pc_reg + offset_0;  // jal or predicted taken branch
        end else begin
            pc_next = pc_reg + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_reg   <= RESET_PC;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            pc_reg <= pc_next;
            if (pc_write) begin
                // a flush kills both younger slots
                s1_valid <= !mispredict;
                s2_valid <= s1_valid && !mispredict;
            end
        end
    end

    // slot payload shifts along with the pipeline
    always_ff @(posedge clk) begin
        if (pc_write) begin
            s1_branch <= is_branch;
            s1_pc     <= pc_reg;
            s1_offset <= offset_0;
            s1_pred   <= pred.lookup_taken;
            s2_branch <= s1_branch;
            s2_pc     <= s1_pc;
            s2_offset <= s1_offset;
            s2_pred   <= s1_pred;
        end
    end

    assign address = pc_reg;

endmodule

`default_nettype wire

/* hdl/branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  wire         clk,
    input  wire         reset_n,
    predict_if.predictor pred
);
    import frontend_pkg::*;

    logic [BANK_SEL_W-1:0]  lookup_bank;
    logic [ENTRY_SEL_W-1:0] lookup_entry;
    logic [BANK_SEL_W-1:0]  update_bank;
    logic [ENTRY_SEL_W-1:0] update_entry;

    logic [NUM_BANKS-1:0] bank_taken;  // rd_taken of every bank
    logic [NUM_BANKS-1:0] bank_wr;

    // pc[1:0] is always zero, bank bits start at 2
    assign lookup_bank  = pred.lookup_pc[2 +: BANK_SEL_W];
    assign lookup_entry = pred.lookup_pc[2 + BANK_SEL_W +: ENTRY_SEL_W];
    assign update_bank  = pred.update_pc[2 +: BANK_SEL_W];
    assign update_entry = pred.update_pc[2 + BANK_SEL_W +: ENTRY_SEL_W];

    genvar b;
    generate
        for (b = 0; b < NUM_BANKS; b++) begin : g_bank
            // only the bank owning update_pc steps its counter
            assign bank_wr[b] = pred.update_valid && (update_bank == BANK_SEL_W'(b));

            predictor_bank u_bank (
                .clk      (clk),
                .reset_n  (reset_n),
                .rd_index (lookup_entry),
                .rd_taken (bank_taken[b]),
                .wr_en    (bank_wr[b]),
                .wr_index (update_entry),
                .wr_taken (pred.update_taken)
            );
        end
    endgenerate

    assign pred.lookup_taken = bank_taken[lookup_bank];  // pick the bank of the fetch pc

endmodule

`default_nettype wire

/* hdl/predictor_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module predictor_bank (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire [frontend_pkg::ENTRY_SEL_W-1:0] rd_index,
    output logic                               rd_taken,
    input  wire                                wr_en,
    input  wire [frontend_pkg::ENTRY_SEL_W-1:0] wr_index,
    input  wire                                wr_taken
);
    import frontend_pkg::*;

    ctr_state_t ctr [BANK_ENTRIES];
    ctr_state_t ctr_cur;
    ctr_state_t ctr_nxt;

    // old value on a same-cycle write, no bypass
    assign rd_taken = ctr[rd_index][1];

    assign ctr_cur = ctr[wr_index];

    // one step toward the outcome, saturating at both ends
    always_comb begin
        ctr_nxt = ctr_cur;
        case (ctr_cur)
            strong_not_taken: ctr_nxt = wr_taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   ctr_nxt = wr_taken ? weak_taken     : strong_not_taken;
            weak_taken:       ctr_nxt = wr_taken ? strong_taken   : weak_not_taken;
            strong_taken:     ctr_nxt = wr_taken ? strong_taken   : weak_taken;
            default:          ctr_nxt = CTR_RESET;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < BANK_ENTRIES; i++) begin
                ctr[i] <= CTR_RESET;
            end
        end else if (wr_en) begin
            ctr[wr_index] <= ctr_nxt;
        end
    end

endmodule

`default_nettype wire

/* hdl/predict_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface predict_if;
    import frontend_pkg::*;

    addr_t lookup_pc;     // pc being fetched
    logic  lookup_taken;  // comb answer, no handshake

    logic  update_valid;  // one step per cycle while high
    addr_t update_pc;     // pc of the resolved branch
    logic  update_taken;

    modport fetch (
        output lookup_pc,
        output update_valid,
        output update_pc,
        output update_taken,
        input  lookup_taken
    );

    modport predictor (
        input  lookup_pc,
        input  update_valid,
        input  update_pc,
        input  update_taken,
        output lookup_taken
    );

endinterface

`default_nettype wire

/* hdl/frontend_pkg.sv */
`default_nettype none

package frontend_pkg;

    // instruction side widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;

    // 2-bit saturating counter, msb set means predict taken
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } ctr_state_t;

    // rv32i opcodes handled by the front end
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;  // beq, bne, blt ...
    localparam opcode_t OPCODE_JAL    = 7'b1101111;

    localparam addr_t RESET_PC = 32'h0000_0000;

    // predictor geometry
    // bank from pc[3:2], entry from pc[7:4]
    localparam int NUM_BANKS    = 4;
    localparam int BANK_ENTRIES = 16;
    localparam int BANK_SEL_W   = $clog2(NUM_BANKS);
    localparam int ENTRY_SEL_W  = $clog2(BANK_ENTRIES);

    localparam ctr_state_t CTR_RESET = weak_not_taken;

endpackage

`default_nettype wire
